// File: design/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// datapath and address width
`define LSU_DATA_W 32

// data memory depth in words
`define LSU_MEM_WORDS 256

// cycles from request acceptance to data_ok
`define LSU_MEM_LAT 2

`endif

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    //////////////////////////////////////////////////
    // memory operation carried down the pipe
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_t;

    // exception codes, ALE is address misaligned
    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ALE  = 6'h09
    } ecode_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage

`default_nettype wire

// File: design/bus_pkg.sv
`include "lsu_macros.svh"
`default_nettype none

package bus_pkg;

    // who owns a request in flight on the shared memory
    typedef enum logic {
        OWNER_DATA  = 1'b0,
        OWNER_FETCH = 1'b1
    } bus_owner_t;

    // one enable per byte lane
    typedef logic [`LSU_DATA_W/8-1:0] wstrb_t;

endpackage

`default_nettype wire

// File: design/mem_req_stage.sv
`include "lsu_macros.svh"
`default_nettype none

module mem_req_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      ex_flush,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire [`LSU_DATA_W-1:0]    in_pc,
    input  wire pipe_pkg::mem_op_t   in_op,
    input  wire [`LSU_DATA_W-1:0]    in_addr,
    input  wire [`LSU_DATA_W-1:0]    in_wdata,
    input  wire [4:0]                in_dest,
    input  wire [`LSU_DATA_W-1:0]    in_alu_result,
    input  wire                      in_gr_we,
    output logic                     out_valid,
    input  wire                      out_ready,
    output logic [`LSU_DATA_W-1:0]   out_pc,
    output pipe_pkg::mem_op_t        out_op,
    output logic [1:0]               out_byte_off,
    output logic [4:0]               out_dest,
    output logic [`LSU_DATA_W-1:0]   out_alu_result,
    output logic                     out_gr_we,
    output logic                     out_wait_mem,
    output pipe_pkg::ecode_t         out_ecode,
    output logic                     req,
    output logic                     wr,
    output logic [`LSU_DATA_W-1:0]   addr,
    output bus_pkg::wstrb_t          wstrb,
    output logic [`LSU_DATA_W-1:0]   wdata,
    input  wire                      addr_ok
);
    import pipe_pkg::*;
    import bus_pkg::*;

    logic misaligned;
    logic needs_mem;
    logic ready_go;
    logic fire;

    always_comb begin
        case (in_op)
            OP_LH, OP_LHU, OP_SH: misaligned = in_addr[0];
            OP_LW, OP_SW:         misaligned = |in_addr[1:0];
            default:              misaligned = 1'b0;
        endcase
    end

    // faulting and non-memory ops go through without touching the bus
    assign needs_mem = in_valid && (is_load(in_op) || is_store(in_op)) && !misaligned;

    // only ask when the next stage can take the instruction on the grant
    assign req      = needs_mem && out_ready && !ex_flush;
    assign ready_go = !needs_mem || (req && addr_ok);
    assign in_ready = !in_valid || ex_flush || (ready_go && out_ready);
    assign fire     = in_valid && ready_go && out_ready && !ex_flush;

    assign wr   = is_store(in_op);
    assign addr = in_addr;

    // lane strobes and store data replicated across lanes
    always_comb begin
        wstrb = '0;
        wdata = in_wdata;
        case (in_op)
            OP_SB: begin
                wstrb = wstrb_t'(1) << in_addr[1:0];
                wdata = {(`LSU_DATA_W/8){in_wdata[7:0]}};
            end
            OP_SH: begin
                wstrb = in_addr[1] ? 4'b1100 : 4'b0011;
                wdata = {(`LSU_DATA_W/16){in_wdata[15:0]}};
            end
            OP_SW: wstrb = '1;
            default: wstrb = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || ex_flush) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc         <= in_pc;
            out_op         <= in_op;
            out_byte_off   <= in_addr[1:0];
            out_dest       <= in_dest;
            out_alu_result <= in_alu_result;
            out_gr_we      <= in_gr_we;
            out_wait_mem   <= needs_mem;
            out_ecode      <= misaligned ? ECODE_ALE : ECODE_NONE;
        end
    end

    // a request waiting for its grant must not change under the arbiter
    assert property (@(posedge clk) disable iff (rst || ex_flush)
        req && !addr_ok |=> $stable(addr) && $stable(wr) && $stable(wdata))
        else $error("mem_req_stage: request changed before addr_ok");

endmodule

`default_nettype wire

// File: design/rdw_stage.sv
`include "lsu_macros.svh"
`default_nettype none

module rdw_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      ex_flush,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire [`LSU_DATA_W-1:0]    in_pc,
    input  wire pipe_pkg::mem_op_t   in_op,
    input  wire [1:0]                in_byte_off,
    input  wire [4:0]                in_dest,
    input  wire [`LSU_DATA_W-1:0]    in_alu_result,
    input  wire                      in_gr_we,
    input  wire                      in_wait_mem,
    input  wire pipe_pkg::ecode_t    in_ecode,
    input  wire                      data_ok,
    input  wire [`LSU_DATA_W-1:0]    rdata,
    output logic                     out_valid,
    input  wire                      out_ready,
    output logic [`LSU_DATA_W-1:0]   out_pc,
    output pipe_pkg::mem_op_t        out_op,
    output logic [1:0]               out_byte_off,
    output logic [4:0]               out_dest,
    output logic [`LSU_DATA_W-1:0]   out_result,
    output logic                     out_gr_we,
    output pipe_pkg::ecode_t         out_ecode
);
    import pipe_pkg::*;

    localparam int DISC_W = $clog2(`LSU_MEM_LAT + 2);

    logic                   buf_valid;
    logic [`LSU_DATA_W-1:0] buf_data;
    logic [DISC_W-1:0]      discard_cnt;
    logic                   discard_now;
    logic                   mem_ok;
    logic                   have_data;
    logic                   outstanding;
    logic                   ready_go;
    logic                   fire;

    //////////////////////////////////////////////////
    // response bookkeeping
    //////////////////////////////////////////////////

    // responses owed to flushed loads are eaten first, they come back in order
    assign discard_now = data_ok && (discard_cnt != '0);
    assign mem_ok      = data_ok && (discard_cnt == '0);
    assign have_data   = buf_valid || mem_ok;

    // still owed to the instruction sitting here
    assign outstanding = in_valid && in_wait_mem && !have_data;

    assign ready_go = !in_wait_mem || have_data;
    assign in_ready = !in_valid || (ready_go && out_ready);
    assign fire     = in_valid && ready_go && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            discard_cnt <= '0;
        end else begin
            discard_cnt <= discard_cnt - DISC_W'(discard_now)
                         + DISC_W'(ex_flush && outstanding);
        end
    end

    // hold the word when it lands while we are stalled
    always_ff @(posedge clk) begin
        if (rst || ex_flush) begin
            buf_valid <= 1'b0;
        end else if (fire) begin
            buf_valid <= 1'b0;
        end else if (mem_ok) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ok && !fire) begin
            buf_data <= rdata;
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || ex_flush) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc       <= in_pc;
            out_op       <= in_op;
            out_byte_off <= in_byte_off;
            out_dest     <= in_dest;
            out_gr_we    <= in_gr_we;
            out_ecode    <= in_ecode;
            // raw word for loads, lane pick happens in writeback
            if (in_wait_mem && is_load(in_op)) begin
                out_result <= buf_valid ? buf_data : rdata;
            end else begin
                out_result <= in_alu_result;
            end
        end
    end

    // every response is either owed to us or marked for discard
    assert property (@(posedge clk) disable iff (rst)
        data_ok |-> (discard_cnt != '0) || (in_valid && in_wait_mem && !buf_valid))
        else $error("rdw_stage: unexpected data_ok");

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`include "lsu_macros.svh"
`default_nettype none

module wb_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      ex_flush,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire [`LSU_DATA_W-1:0]    in_pc,
    input  wire pipe_pkg::mem_op_t   in_op,
    input  wire [1:0]                in_byte_off,
    input  wire [4:0]                in_dest,
    input  wire [`LSU_DATA_W-1:0]    in_result,
    input  wire                      in_gr_we,
    input  wire pipe_pkg::ecode_t    in_ecode,
    output logic                     retire_valid,
    input  wire                      retire_ready,
    output logic [`LSU_DATA_W-1:0]   retire_pc,
    output logic                     retire_we,
    output logic [4:0]               retire_dest,
    output logic [`LSU_DATA_W-1:0]   retire_wdata,
    output pipe_pkg::ecode_t         retire_ecode
);
    import pipe_pkg::*;

    logic [7:0]             byte_lane;
    logic [15:0]            half_lane;
    logic [`LSU_DATA_W-1:0] wb_value;

    // lane select then extend
    always_comb begin
        byte_lane = in_result[{in_byte_off, 3'b000} +: 8];
        half_lane = in_byte_off[1] ? in_result[31:16] : in_result[15:0];
        case (in_op)
            OP_LB:   wb_value = {{(`LSU_DATA_W-8){byte_lane[7]}}, byte_lane};
            OP_LBU:  wb_value = {{(`LSU_DATA_W-8){1'b0}}, byte_lane};
            OP_LH:   wb_value = {{(`LSU_DATA_W-16){half_lane[15]}}, half_lane};
            OP_LHU:  wb_value = {{(`LSU_DATA_W-16){1'b0}}, half_lane};
            default: wb_value = in_result;
        endcase
    end

    assign in_ready = !retire_valid || retire_ready;

    always_ff @(posedge clk) begin
        if (rst || ex_flush) begin
            retire_valid <= 1'b0;
        end else if (in_ready) begin
            retire_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            retire_pc    <= in_pc;
            retire_dest  <= in_dest;
            retire_wdata <= wb_value;
            retire_ecode <= in_ecode;
            // no register write for stores or faults
            retire_we    <= in_gr_we && !is_store(in_op) && (in_ecode == ECODE_NONE);
        end
    end

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
`include "lsu_macros.svh"
`default_nettype none

module bus_arbiter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      data_req,
    input  wire                      data_wr,
    input  wire [`LSU_DATA_W-1:0]    data_addr,
    input  wire bus_pkg::wstrb_t     data_wstrb,
    input  wire [`LSU_DATA_W-1:0]    data_wdata,
    output logic                     data_addr_ok,
    output logic                     data_data_ok,
    output logic [`LSU_DATA_W-1:0]   data_rdata,
    input  wire                      fetch_req,
    input  wire [`LSU_DATA_W-1:0]    fetch_addr,
    output logic                     fetch_addr_ok,
    output logic                     fetch_data_ok,
    output logic [`LSU_DATA_W-1:0]   fetch_rdata,
    output logic                     mem_req,
    output logic                     mem_wr,
    output logic [`LSU_DATA_W-1:0]   mem_addr,
    output bus_pkg::wstrb_t          mem_wstrb,
    output logic [`LSU_DATA_W-1:0]   mem_wdata,
    input  wire                      mem_addr_ok,
    input  wire                      mem_data_ok,
    input  wire [`LSU_DATA_W-1:0]    mem_rdata
);
    import bus_pkg::*;

    localparam int DEPTH = `LSU_MEM_LAT + 1;
    localparam int PTR_W = $clog2(DEPTH);

    bus_owner_t       owner_q [DEPTH];
    bus_owner_t       head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // grant, data port first
    //////////////////////////////////////////////////
    assign data_addr_ok  = data_req && mem_addr_ok;
    assign fetch_addr_ok = fetch_req && !data_req && mem_addr_ok;

    assign mem_req   = data_req || fetch_req;
    assign mem_wr    = data_req && data_wr;
    assign mem_addr  = data_req ? data_addr : fetch_addr;
    assign mem_wstrb = data_req ? data_wstrb : '0;
    assign mem_wdata = data_wdata;

    //////////////////////////////////////////////////
    // response routing by owner order
    //////////////////////////////////////////////////
    assign push = mem_req && mem_addr_ok;
    assign pop  = mem_data_ok;
    assign head = owner_q[rd_ptr];

    assign data_data_ok  = pop && (head == OWNER_DATA);
    assign fetch_data_ok = pop && (head == OWNER_FETCH);
    assign data_rdata    = mem_rdata;
    assign fetch_rdata   = mem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            owner_q[wr_ptr] <= data_req ? OWNER_DATA : OWNER_FETCH;
        end
    end

    assert property (@(posedge clk) disable iff (rst) push && !pop |-> count < DEPTH)
        else $error("bus_arbiter: owner FIFO overflow");
    assert property (@(posedge clk) disable iff (rst) pop |-> count != 0)
        else $error("bus_arbiter: data_ok with no owner queued");

endmodule

`default_nettype wire

// File: design/sram_like_mem.sv
`include "lsu_macros.svh"
`default_nettype none

module sram_like_mem (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req,
    input  wire                      wr,
    input  wire [`LSU_DATA_W-1:0]    addr,
    input  wire bus_pkg::wstrb_t     wstrb,
    input  wire [`LSU_DATA_W-1:0]    wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [`LSU_DATA_W-1:0]   rdata
);
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int LAT   = `LSU_MEM_LAT;

    logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
    logic [`LSU_DATA_W-1:0] data_sr [LAT];
    logic [LAT-1:0]         vld_sr;
    logic [IDX_W-1:0]       idx;
    logic                   accept;

    initial begin
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // never stalls, one request per cycle
    assign addr_ok = 1'b1;
    assign accept  = req && addr_ok;
    assign idx     = addr[IDX_W+1:2];

    always @(posedge clk) begin
        if (accept && wr) begin
            for (int b = 0; b < `LSU_DATA_W/8; b++) begin
                if (wstrb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // fixed latency pipe, word sampled before this edge's write
    always_ff @(posedge clk) begin
        data_sr[0] <= mem[idx];
        for (int i = 1; i < LAT; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= LAT'({vld_sr, accept});
        end
    end

    assign data_ok = vld_sr[LAT-1];
    assign rdata   = data_sr[LAT-1];

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`include "lsu_macros.svh"
`default_nettype none

module lsu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      ex_flush,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire [`LSU_DATA_W-1:0]    in_pc,
    input  wire pipe_pkg::mem_op_t   in_op,
    input  wire [`LSU_DATA_W-1:0]    in_addr,
    input  wire [`LSU_DATA_W-1:0]    in_wdata,
    input  wire [4:0]                in_dest,
    input  wire [`LSU_DATA_W-1:0]    in_alu_result,
    input  wire                      in_gr_we,
    input  wire                      fetch_req,
    input  wire [`LSU_DATA_W-1:0]    fetch_addr,
    output logic                     fetch_addr_ok,
    output logic                     fetch_data_ok,
    output logic [`LSU_DATA_W-1:0]   fetch_rdata,
    output logic                     retire_valid,
    input  wire                      retire_ready,
    output logic [`LSU_DATA_W-1:0]   retire_pc,
    output logic                     retire_we,
    output logic [4:0]               retire_dest,
    output logic [`LSU_DATA_W-1:0]   retire_wdata,
    output pipe_pkg::ecode_t         retire_ecode
);
    import pipe_pkg::*;
    import bus_pkg::*;

    // request stage to read wait
    logic                   mr_valid, mr_ready, mr_gr_we, mr_wait_mem;
    logic [`LSU_DATA_W-1:0] mr_pc, mr_alu_result;
    mem_op_t                mr_op;
    logic [1:0]             mr_byte_off;
    logic [4:0]             mr_dest;
    ecode_t                 mr_ecode;

    // read wait to writeback
    logic                   rw_valid, rw_ready, rw_gr_we;
    logic [`LSU_DATA_W-1:0] rw_pc, rw_result;
    mem_op_t                rw_op;
    logic [1:0]             rw_byte_off;
    logic [4:0]             rw_dest;
    ecode_t                 rw_ecode;

    // data port and memory side
    logic                   d_req, d_wr, d_addr_ok, d_data_ok;
    logic [`LSU_DATA_W-1:0] d_addr, d_wdata, d_rdata;
    wstrb_t                 d_wstrb, m_wstrb;
    logic                   m_req, m_wr, m_addr_ok, m_data_ok;
    logic [`LSU_DATA_W-1:0] m_addr, m_wdata, m_rdata;

    mem_req_stage u_mem_req (
        .clk, .rst, .ex_flush,
        .in_valid, .in_ready, .in_pc, .in_op, .in_addr, .in_wdata,
        .in_dest, .in_alu_result, .in_gr_we,
        .out_valid(mr_valid), .out_ready(mr_ready), .out_pc(mr_pc), .out_op(mr_op),
        .out_byte_off(mr_byte_off), .out_dest(mr_dest), .out_alu_result(mr_alu_result),
        .out_gr_we(mr_gr_we), .out_wait_mem(mr_wait_mem), .out_ecode(mr_ecode),
        .req(d_req), .wr(d_wr), .addr(d_addr), .wstrb(d_wstrb), .wdata(d_wdata),
        .addr_ok(d_addr_ok)
    );

    rdw_stage u_rdw (
        .clk, .rst, .ex_flush,
        .in_valid(mr_valid), .in_ready(mr_ready), .in_pc(mr_pc), .in_op(mr_op),
        .in_byte_off(mr_byte_off), .in_dest(mr_dest), .in_alu_result(mr_alu_result),
        .in_gr_we(mr_gr_we), .in_wait_mem(mr_wait_mem), .in_ecode(mr_ecode),
        .data_ok(d_data_ok), .rdata(d_rdata),
        .out_valid(rw_valid), .out_ready(rw_ready), .out_pc(rw_pc), .out_op(rw_op),
        .out_byte_off(rw_byte_off), .out_dest(rw_dest), .out_result(rw_result),
        .out_gr_we(rw_gr_we), .out_ecode(rw_ecode)
    );

    wb_stage u_wb (
        .clk, .rst, .ex_flush,
        .in_valid(rw_valid), .in_ready(rw_ready), .in_pc(rw_pc), .in_op(rw_op),
        .in_byte_off(rw_byte_off), .in_dest(rw_dest), .in_result(rw_result),
        .in_gr_we(rw_gr_we), .in_ecode(rw_ecode),
        .retire_valid, .retire_ready, .retire_pc, .retire_we, .retire_dest,
        .retire_wdata, .retire_ecode
    );

    bus_arbiter u_arb (
        .clk, .rst,
        .data_req(d_req), .data_wr(d_wr), .data_addr(d_addr), .data_wstrb(d_wstrb),
        .data_wdata(d_wdata), .data_addr_ok(d_addr_ok), .data_data_ok(d_data_ok),
        .data_rdata(d_rdata),
        .fetch_req, .fetch_addr, .fetch_addr_ok, .fetch_data_ok, .fetch_rdata,
        .mem_req(m_req), .mem_wr(m_wr), .mem_addr(m_addr), .mem_wstrb(m_wstrb),
        .mem_wdata(m_wdata), .mem_addr_ok(m_addr_ok), .mem_data_ok(m_data_ok),
        .mem_rdata(m_rdata)
    );

    sram_like_mem u_mem (
        .clk, .rst,
        .req(m_req), .wr(m_wr), .addr(m_addr), .wstrb(m_wstrb), .wdata(m_wdata),
        .addr_ok(m_addr_ok), .data_ok(m_data_ok), .rdata(m_rdata)
    );

endmodule

`default_nettype wire

// File: dv/lsu_tb.sv
`include "lsu_macros.svh"
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_pkg::*;

    logic clk, rst, ex_flush, in_valid, in_ready, in_gr_we;
    logic [31:0] in_pc, in_addr, in_wdata, in_alu_result, fetch_addr, fetch_rdata;
    mem_op_t in_op;
    logic [4:0] in_dest, retire_dest;
    logic fetch_req, fetch_addr_ok, fetch_data_ok;
    logic retire_valid, retire_ready, retire_we;
    logic [31:0] retire_pc, retire_wdata;
    ecode_t retire_ecode;

    // reference memory and expected retire stream
    logic [31:0] ref_mem [256];
    logic [31:0] exp_pc[$], exp_data[$];
    logic [4:0]  exp_dest[$];
    logic        exp_we[$], exp_chk[$];
    ecode_t      exp_ecode[$];
    logic [7:0]  fetch_idx[$];
    logic [7:0]  saved_idx [8];
    logic [15:0] lfsr_q, stall_q, fetch_q;
    logic [31:0] pc_cnt;
    logic        stall_mode, ready_force, fetch_on, fetch_got;
    int          fetch_cnt;

    lsu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, inout logic [15:0] s, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %h expected %h", $time, name, got, exp);
            fail_now("value mismatch");
        end
    endtask

    task automatic check_ecode(input string name, input ecode_t got, input ecode_t exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
            fail_now("exception code mismatch");
        end
    endtask

    task automatic check_bool(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %b expected %b", $time, name, got, exp);
            fail_now("flag mismatch");
        end
    endtask

    // lane pick and extend, as a load retires
    function automatic logic [31:0] load_value(mem_op_t op, logic [31:0] w, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            default: return w;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // drive tasks, entered and left on a falling edge
    //////////////////////////////////////////////////
    task automatic issue(input mem_op_t op, input logic [31:0] a, input logic [31:0] d);
        int n;
        logic aligned;
        logic [7:0] idx;
        n = 0;
        idx = a[9:2];
        aligned = (op inside {OP_LH, OP_LHU, OP_SH}) ? !a[0] :
                  (op inside {OP_LW, OP_SW}) ? (a[1:0] == 2'b00) : 1'b1;
        exp_pc.push_back(pc_cnt);
        exp_dest.push_back(pc_cnt[6:2]);
        if (!aligned) begin
            exp_data.push_back('0);
            exp_we.push_back(1'b0);
            exp_chk.push_back(1'b0);
            exp_ecode.push_back(ECODE_ALE);
        end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
            if (op == OP_SW) ref_mem[idx] = d;
            else if (op == OP_SH) ref_mem[idx][16*a[1] +: 16] = d[15:0];
            else ref_mem[idx][8*a[1:0] +: 8] = d[7:0];
            exp_data.push_back('0);
            exp_we.push_back(1'b0);
            exp_chk.push_back(1'b0);
            exp_ecode.push_back(ECODE_NONE);
        end else begin
            exp_data.push_back(load_value(op, ref_mem[idx], a[1:0]));
            exp_we.push_back(1'b1);
            exp_chk.push_back(1'b1);
            exp_ecode.push_back(ECODE_NONE);
        end
        in_valid = 1'b1;
        in_op = op;
        in_addr = a;
        in_wdata = d;
        in_pc = pc_cnt;
        in_dest = pc_cnt[6:2];
        in_alu_result = a;
        in_gr_we = 1'b1;
        pc_cnt = pc_cnt + 4;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
            n++;
            if (n > 200) fail_now("timeout: instruction never accepted");
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_pc.size() != 0 || fetch_idx.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > 500) fail_now("timeout: retires or fetch responses missing");
        end
    endtask

    // retire monitor and retire_ready driver
    initial begin
        stall_q = 16'd21;
        forever begin
            logic [31:0] r;
            @(negedge clk);
            // set ready for the next edge before checking what transfers on it
            rand_bits(2, stall_q, r);
            retire_ready = stall_mode ? (r[1:0] != 2'b00) : ready_force;
            if (!rst && retire_valid && retire_ready) begin
                if (exp_pc.size() == 0) fail_now("retire seen with no instruction pending");
                check_word("retire_pc", retire_pc, exp_pc.pop_front());
                check_word("retire_dest", 32'(retire_dest), 32'(exp_dest.pop_front()));
                r = exp_data.pop_front();
                if (exp_chk.pop_front()) check_word("retire_wdata", retire_wdata, r);
                check_bool("retire_we", retire_we, exp_we.pop_front());
                check_ecode("retire_ecode", retire_ecode, exp_ecode.pop_front());
            end
        end
    end

    // fetch port traffic, checked against the reference memory
    initial begin
        fetch_q = 16'd21;
        fetch_got = 1'b0;
        fetch_cnt = 0;
        forever begin
            logic [31:0] r;
            @(negedge clk);
            if (fetch_data_ok) begin
                if (fetch_idx.size() == 0) fail_now("fetch response with no fetch pending");
                check_word("fetch_rdata", fetch_rdata, ref_mem[fetch_idx.pop_front()]);
                fetch_cnt++;
            end
            if (fetch_got || !fetch_req) begin
                rand_bits(8, fetch_q, r);
                fetch_req = fetch_on;
                fetch_addr = {22'd0, r[7:0], 2'b00};
            end
            #1;
            fetch_got = fetch_req && fetch_addr_ok;
            if (fetch_got) fetch_idx.push_back(fetch_addr[9:2]);
        end
    end

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_word_rw();
        logic [31:0] r, d;
        for (int i = 0; i < 8; i++) begin
            rand_bits(8, lfsr_q, r);
            rand_bits(32, lfsr_q, d);
            saved_idx[i] = r[7:0];
            issue(OP_SW, {22'd0, r[7:0], 2'b00}, d);
        end
        for (int i = 0; i < 8; i++) issue(OP_LW, {22'd0, saved_idx[i], 2'b00}, '0);
        wait_drain();
    endtask

    task automatic test_sub_word();
        logic [31:0] d;
        rand_bits(32, lfsr_q, d);
        issue(OP_SW, 32'h40, d);
        issue(OP_SB, 32'h41, 32'h0000_0085);
        issue(OP_SH, 32'h42, 32'h0000_f00d);
        for (int off = 0; off < 4; off++) begin
            issue(OP_LB, 32'h40 + off, '0);
            issue(OP_LBU, 32'h40 + off, '0);
        end
        issue(OP_LH, 32'h40, '0);
        issue(OP_LHU, 32'h40, '0);
        issue(OP_LH, 32'h42, '0);
        issue(OP_LHU, 32'h42, '0);
        wait_drain();
    endtask

    task automatic test_misaligned();
        issue(OP_SW, 32'h80, 32'h1234_5678);
        issue(OP_LH, 32'h81, '0);
        issue(OP_LW, 32'h82, '0);
        issue(OP_SW, 32'h81, 32'hdead_beef);
        issue(OP_LW, 32'h80, '0);
        wait_drain();
    endtask

    task automatic test_backpressure();
        stall_mode = 1'b1;
        for (int i = 0; i < 8; i++) issue(OP_LW, {22'd0, saved_idx[i], 2'b00}, '0);
        wait_drain();
        stall_mode = 1'b0;
    endtask

    task automatic test_fetch();
        logic [31:0] r;
        fetch_on = 1'b1;
        for (int i = 0; i < 12; i++) begin
            rand_bits(8, lfsr_q, r);
            issue(OP_LW, {22'd0, r[7:0], 2'b00}, '0);
        end
        fetch_on = 1'b0;
        wait_drain();
        if (fetch_cnt == 0) fail_now("no fetch response arrived during data traffic");
    endtask

    task automatic test_flush();
        ready_force = 1'b0;
        repeat (2) @(negedge clk);
        issue(OP_LW, {22'd0, saved_idx[0], 2'b00}, '0);
        issue(OP_LW, {22'd0, saved_idx[1], 2'b00}, '0);
        ex_flush = 1'b1;
        @(negedge clk);
        ex_flush = 1'b0;
        check_bool("retire_valid", retire_valid, 1'b0);
        // flushed loads never retire
        exp_pc.delete();
        exp_dest.delete();
        exp_data.delete();
        exp_we.delete();
        exp_chk.delete();
        exp_ecode.delete();
        ready_force = 1'b1;
        for (int i = 2; i < 6; i++) issue(OP_LW, {22'd0, saved_idx[i], 2'b00}, '0);
        wait_drain();
    endtask

    initial begin
        rst = 1'b1;
        ex_flush = 1'b0;
        in_valid = 1'b0;
        in_op = OP_NONE;
        in_pc = '0;
        in_addr = '0;
        in_wdata = '0;
        in_dest = '0;
        in_alu_result = '0;
        in_gr_we = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        retire_ready = 1'b1;
        ready_force = 1'b1;
        stall_mode = 1'b0;
        fetch_on = 1'b0;
        lfsr_q = 16'd21;
        pc_cnt = 32'h1c00_0000;
        for (int i = 0; i < 256; i++) ref_mem[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_word_rw();
        test_sub_word();
        test_misaligned();
        test_backpressure();
        test_fetch();
        test_flush();
        repeat (4) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/pipe_pkg.sv
design/bus_pkg.sv
design/mem_req_stage.sv
design/rdw_stage.sv
design/wb_stage.sv
design/bus_arbiter.sv
design/sram_like_mem.sv
design/lsu_top.sv
dv/lsu_tb.sv

// File: Makefile
SIM      := verilator
TOP      := lsu_tb
FILELIST := filelist.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\*\* FAILED \*\*\*" $(LOG); then exit 1; fi
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
